/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_denseLayer
FILELIST ?= denseLayer.f
OBJDIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Finished with no errors
VFLAGS ?= --binary -j 0

SIM := $(OBJDIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM) weights.mem
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* activationBuffer.sv */
`timescale 1ns/100ps

module activationBuffer(
	input logic clk,
	input logic reset,
	input logic wrEn,
	input nnPkg::inputIndex_t wrIndex,
	input nnPkg::activation_t wrData,
	input nnPkg::inputIndex_t rdIndex [nnPkg::numNeurons],
	output nnPkg::activation_t rdData [nnPkg::numNeurons]
);
	import nnPkg::*;

	activation_t regs [numInputs];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < numInputs; i++)
				regs[i] <= '0;
		end
		else if (wrEn && wrIndex < numInputs)
			regs[wrIndex] <= wrData;    // Index 15 and up is dropped.
	end

	// One read port per neuron unit; index 15 reads as zero.
	always_comb
	begin
		for (int n = 0; n < numNeurons; n++)
		begin
			if (rdIndex[n] < numInputs)
				rdData[n] = regs[rdIndex[n]];
			else
				rdData[n] = '0;
		end
	end

endmodule

/* busArbiter.sv */
`timescale 1ns/100ps

module busArbiter(
	input logic clk,
	input logic reset,
	weightBus.arbiter bus [nnPkg::numNeurons],
	output logic rdEn,
	output nnPkg::romAddr_t rdAddr,
	input nnPkg::romWord_t rdData
);
	import nnPkg::*;

	logic [numNeurons-1:0] req;
	logic [numNeurons-1:0] grant;
	romAddr_t addr [numNeurons];
	neuronId_t lastGrant;
	neuronId_t grantId;
	neuronId_t cand;

	for (genvar n = 0; n < numNeurons; n++)
	begin : gBusPort
		assign req[n] = bus[n].req;
		assign addr[n] = bus[n].addr;
		assign bus[n].grant = grant[n];
		assign bus[n].data = rdData;    // Only the unit granted last cycle takes it.
	end

	// Search starts at the unit after the last one granted.
	always_comb
	begin
		grant = '0;
		grantId = lastGrant;
		cand = lastGrant;
		for (int k = 1; k <= numNeurons; k++)
		begin
			cand = neuronId_t'(lastGrant + k);
			if (grant == '0 && req[cand])
			begin
				grant[cand] = 1'b1;
				grantId = cand;
			end
		end
	end

	assign rdEn = |grant;
	assign rdAddr = addr[grantId];

	always_ff @(posedge clk)
	begin
		if (reset)
			lastGrant <= neuronId_t'(numNeurons - 1);    // Unit 0 wins first.
		else if (rdEn)
			lastGrant <= grantId;
	end

endmodule

/* denseLayer.f */
nnPkg.sv
weightBus.sv
weightRom.sv
busArbiter.sv
activationBuffer.sv
neuronUnit.sv
denseLayer.sv
tb_denseLayer.sv

/* denseLayer.sv */
`timescale 1ns/100ps

module denseLayer(
	input logic clk,
	input logic reset,
	input logic loadValid,
	input nnPkg::inputIndex_t loadIndex,
	input nnPkg::activation_t loadData,
	input logic start,
	output logic busy,
	output logic done,
	output nnPkg::activation_t [nnPkg::numNeurons-1:0] results
);
	import nnPkg::*;

	logic launch;
	logic [numNeurons-1:0] unitFinished;
	inputIndex_t actIndex [numNeurons];
	activation_t actData [numNeurons];
	activation_t unitResult [numNeurons];
	logic rdEn;
	romAddr_t rdAddr;
	romWord_t rdData;

	weightBus wBus [numNeurons] ();

	assign launch = start & ~busy;    // Start is ignored during a run.

	activationBuffer actBuf(
		.clk(clk),
		.reset(reset),
		.wrEn(loadValid & ~busy),
		.wrIndex(loadIndex),
		.wrData(loadData),
		.rdIndex(actIndex),
		.rdData(actData)
	);

	for (genvar n = 0; n < numNeurons; n++)
	begin : gNeuron
		neuronUnit #(.neuronIndex(n)) unit(
			.clk(clk),
			.reset(reset),
			.start(launch),
			.bus(wBus[n]),
			.actIndex(actIndex[n]),
			.actData(actData[n]),
			.finished(unitFinished[n]),
			.result(unitResult[n])
		);
	end

	busArbiter arb(
		.clk(clk),
		.reset(reset),
		.bus(wBus),
		.rdEn(rdEn),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

	weightRom rom(
		.clk(clk),
		.rdEn(rdEn),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

	// Done and the result latch happen once, when every unit has finished.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			results <= '0;
		end
		else
		begin
			done <= busy & (&unitFinished);
			if (launch)
				busy <= 1'b1;
			else if (busy && &unitFinished)
			begin
				busy <= 1'b0;
				for (int n = 0; n < numNeurons; n++)
					results[n] <= unitResult[n];
			end
		end
	end

endmodule

/* neuronUnit.sv */
`timescale 1ns/100ps

module neuronUnit #(
	parameter int neuronIndex = 0
)(
	input logic clk,
	input logic reset,
	input logic start,
	weightBus.requester bus,
	output nnPkg::inputIndex_t actIndex,
	input nnPkg::activation_t actData,
	output logic finished,
	output nnPkg::activation_t result
);
	import nnPkg::*;

	localparam inputIndex_t lastWord = inputIndex_t'(wordsPerNeuron - 1);

	logic issuing;
	inputIndex_t issueIdx;
	logic dataValid;
	inputIndex_t dataIdx;
	acc_t acc;
	acc_t term;
	acc_t nextAcc;

	// Rectify, round half up on bit 5, saturate at 127.
	function automatic activation_t applyRule(acc_t sum);
		acc_t rounded;
		rounded = (sum >>> fracShift) + acc_t'(sum[fracShift-1]);
		if (sum < 0)
			return '0;
		else if (sum >= acc_t'((satMax + 1) << fracShift))
			return activation_t'(satMax);
		else if (rounded > satMax)
			return activation_t'(satMax);    // 127 does not carry to 128.
		else
			return activation_t'(rounded);
	endfunction

	// ====================
	// Request side
	// ====================

	assign bus.req = issuing;
	assign bus.addr = romAddr_t'(neuronIndex * wordsPerNeuron + issueIdx);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			issuing <= 1'b0;
			issueIdx <= '0;
			dataValid <= 1'b0;
			finished <= 1'b0;
		end
		else if (start)
		begin
			issuing <= 1'b1;
			issueIdx <= '0;
			dataValid <= 1'b0;
			finished <= 1'b0;
		end
		else
		begin
			dataValid <= issuing & bus.grant;
			if (issuing && bus.grant)
			begin
				issueIdx <= issueIdx + 1'b1;
				if (issueIdx == lastWord)
					issuing <= 1'b0;    // Bias was the last request.
			end
			if (dataValid && dataIdx == lastWord)
				finished <= 1'b1;
		end
	end

	// ====================
	// Accumulate side
	// ====================

	assign actIndex = dataIdx;    // Activation lines up with the returning weight.

	always_comb
	begin
		if (dataIdx == lastWord)
			term = acc_t'(bus.data);
		else
			term = acc_t'(actData) * acc_t'(bus.data);
		nextAcc = acc + term;
	end

	always_ff @(posedge clk)
	begin
		if (start)
			acc <= '0;
		else if (dataValid)
			acc <= nextAcc;
		if (issuing && bus.grant)
			dataIdx <= issueIdx;
		if (dataValid && dataIdx == lastWord)
			result <= applyRule(nextAcc);
	end

endmodule

/* nnPkg.sv */
package nnPkg;

	// ====================
	// Layer sizes
	// ====================

	localparam int numInputs = 15;                    // Activations per neuron.
	localparam int numNeurons = 4;                    // Neuron units in the layer.
	localparam int wordsPerNeuron = numInputs + 1;    // Last word of each row is the bias.
	localparam int romDepth = numNeurons * wordsPerNeuron;

	// ====================
	// Widths
	// ====================

	localparam int actWidth = 8;
	localparam int romWidth = 16;
	localparam int accWidth = 23;

	// ====================
	// Quantization
	// ====================

	localparam int fracShift = 6;                     // Fraction bits dropped on output.
	localparam int satMax = 127;                      // Largest output value.

	// ====================
	// Types
	// ====================

	// Activations and layer outputs share one type.
	typedef logic signed [actWidth-1:0] activation_t;

	// Weights are sign-extended from 8 bits, the bias uses all 16.
	typedef logic signed [romWidth-1:0] romWord_t;

	typedef logic [$clog2(romDepth)-1:0] romAddr_t;
	typedef logic [$clog2(wordsPerNeuron)-1:0] inputIndex_t;
	typedef logic [$clog2(numNeurons)-1:0] neuronId_t;

	typedef logic signed [accWidth-1:0] acc_t;

endpackage

/* tb_denseLayer.sv */
`timescale 1ns/100ps

module tb_denseLayer;
	import nnPkg::*;

	typedef activation_t actVector_t [numInputs];
	typedef activation_t [numNeurons-1:0] resultVec_t;

	logic clk;
	logic reset;
	logic loadValid;
	inputIndex_t loadIndex;
	activation_t loadData;
	logic start;
	logic busy;
	logic done;
	resultVec_t results;

	romWord_t romImage [romDepth];
	actVector_t shadow;              // Contents the buffer should hold.
	actVector_t vec;
	resultVec_t expectedQ [$];       // One entry per accepted start.
	resultVec_t heldResults;
	resultVec_t expectedNow;
	logic monitorOn;
	int errorCount;
	int checkCount;
	int runCount;
	int doneCount;

	denseLayer dut_i(
		.clk(clk),
		.reset(reset),
		.loadValid(loadValid),
		.loadIndex(loadIndex),
		.loadData(loadData),
		.start(start),
		.busy(busy),
		.done(done),
		.results(results)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// ====================
	// Reference model
	// ====================

	function automatic activation_t referenceOutput(int neuron, actVector_t acts);
		int base;
		int sum;
		int scaled;
		base = neuron * wordsPerNeuron;
		sum = int'(romImage[base + numInputs]);    // Bias word.
		for (int i = 0; i < numInputs; i++)
			sum += int'(acts[i]) * int'(romImage[base + i]);
		if (sum < 0)
			return activation_t'(0);
		if (sum >= 8192)
			return activation_t'(127);
		scaled = (sum + 32) / 64;    // Round half up, sum is never negative here.
		if (scaled > 127)
			scaled = 127;
		return activation_t'(scaled);
	endfunction

	function automatic resultVec_t referenceVector(actVector_t acts);
		resultVec_t r;
		for (int n = 0; n < numNeurons; n++)
			r[n] = referenceOutput(n, acts);
		return r;
	endfunction

	// ====================
	// Helpers
	// ====================

	task automatic checkValue(string name, int actual, int expected);
		checkCount++;
		if (actual != expected)
		begin
			errorCount++;
			$display("error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic finishRun();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	task automatic idle(int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic loadElement(int index, activation_t value);
		logic accepted;
		accepted = !busy;    // Sampled by the DUT at the coming edge.
		loadValid = 1'b1;
		loadIndex = inputIndex_t'(index);
		loadData = value;
		@(posedge clk);
		#1;
		loadValid = 1'b0;
		if (accepted && index < numInputs)
			shadow[index] = value;
	endtask

	task automatic loadVector(actVector_t v);
		for (int i = 0; i < numInputs; i++)
			loadElement(i, v[i]);
	endtask

	task automatic loadShuffled(actVector_t v);
		int order [numInputs];
		int j;
		int tmp;
		for (int i = 0; i < numInputs; i++)
			order[i] = i;
		for (int i = numInputs - 1; i > 0; i--)
		begin
			j = int'($urandom_range(i, 0));
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < numInputs; i++)
			loadElement(order[i], v[order[i]]);
	endtask

	task automatic randomVector();
		for (int i = 0; i < numInputs; i++)
			vec[i] = activation_t'($urandom_range(255, 0));
	endtask

	task automatic pulseStart();
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic startRun();
		expectedQ.push_back(referenceVector(shadow));
		runCount++;
		pulseStart();
	endtask

	task automatic waitDone();
		int cycles;
		cycles = 0;
		while (!done && cycles < 2000)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!done)
		begin
			$display("Timeout: no done pulse within 2000 cycles at %0t ns", $time);
			errorCount++;
			finishRun();
		end
	endtask

	// Leaves the caller one cycle after done, where a back-to-back start goes.
	task automatic runOnce();
		startRun();
		waitDone();
		idle(1);
		checkValue("done pulse count", doneCount, runCount);
	endtask

	// One activation changes in the done cycle, so the second run sees a new vector.
	task automatic runBackToBack(int index, activation_t value);
		startRun();
		waitDone();
		loadElement(index, value);
		checkValue("done pulse count", doneCount, runCount);
		runOnce();
	endtask

	// ====================
	// Compare process
	// ====================

	always @(negedge clk)
	begin
		if (monitorOn)
		begin
			if (done)
			begin
				doneCount++;
				checkValue("busy at done", int'(busy), 0);
				if (expectedQ.size() == 0)
				begin
					errorCount++;
					$display("Done pulse at %0t ns with no run in progress", $time);
				end
				else
				begin
					expectedNow = expectedQ.pop_front();
					for (int n = 0; n < numNeurons; n++)
						checkValue($sformatf("results[%0d]", n), int'(results[n]),
							int'(expectedNow[n]));
				end
				heldResults = results;
			end
			else
			begin
				for (int n = 0; n < numNeurons; n++)
					checkValue($sformatf("results[%0d] between runs", n), int'(results[n]),
						int'(heldResults[n]));
			end
		end
	end

	// ====================
	// Stimulus
	// ====================

	initial
	begin
		reset = 1'b1;
		loadValid = 1'b0;
		loadIndex = '0;
		loadData = '0;
		start = 1'b0;
		monitorOn = 1'b0;
		errorCount = 0;
		checkCount = 0;
		runCount = 0;
		doneCount = 0;
		heldResults = '0;
		for (int i = 0; i < numInputs; i++)
			shadow[i] = '0;
		void'($urandom(32'h32ed));
		$readmemh("weights.mem", romImage);
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		monitorOn = 1'b1;

		checkValue("busy", int'(busy), 0);
		checkValue("done", int'(done), 0);
		for (int n = 0; n < numNeurons; n++)
			checkValue($sformatf("results[%0d] after reset", n), int'(results[n]), 0);
		runOnce();    // Cleared buffer, so only the biases count.

		for (int i = 0; i < numInputs; i++)
			vec[i] = activation_t'(1);
		loadVector(vec);
		runOnce();
		for (int i = 0; i < numInputs; i++)
			vec[i] = (i % 2 == 0) ? activation_t'(64) : activation_t'(-64);
		loadVector(vec);
		runOnce();

		repeat (50)
		begin
			randomVector();
			loadShuffled(vec);
			runOnce();
		end

		for (int i = 0; i < numInputs; i++)
			vec[i] = activation_t'(127);
		loadVector(vec);
		runOnce();
		for (int i = 0; i < numInputs; i++)
			vec[i] = activation_t'(-128);
		loadVector(vec);
		runOnce();
		for (int i = 0; i < numInputs; i++)
			vec[i] = '0;
		vec[3] = activation_t'(127);
		loadVector(vec);
		loadElement(15, activation_t'(85));    // Out of range, the buffer drops it.
		runOnce();

		// Start and loads during a run must not disturb it.
		randomVector();
		loadVector(vec);
		startRun();
		checkValue("busy", int'(busy), 1);
		idle(2);
		pulseStart();
		for (int i = 0; i < 4; i++)
			loadElement(i, activation_t'($urandom_range(255, 0)));
		waitDone();
		idle(1);
		checkValue("done pulse count", doneCount, runCount);

		// Neuron 0 moves from 5 to 35 between these two runs.
		for (int i = 0; i < numInputs; i++)
			vec[i] = '0;
		loadVector(vec);
		runBackToBack(14, activation_t'(127));
		randomVector();
		loadShuffled(vec);
		runBackToBack(0, activation_t'($urandom_range(255, 0)));
		idle(5);

		checkValue("runs still pending", expectedQ.size(), 0);
		finishRun();
	end

endmodule

/* weightBus.sv */
`timescale 1ns/100ps

interface weightBus;
	import nnPkg::*;

	logic req;          // Held with addr until grant.
	romAddr_t addr;
	logic grant;        // At most one bus granted per cycle.
	romWord_t data;     // Valid the cycle after grant.

	modport requester(
		output req,
		output addr,
		input grant,
		input data
	);

	modport arbiter(
		input req,
		input addr,
		output grant,
		output data
	);

endinterface

/* weightRom.sv */
`timescale 1ns/100ps

module weightRom(
	input logic clk,
	input logic rdEn,
	input nnPkg::romAddr_t rdAddr,
	output nnPkg::romWord_t rdData
);
	import nnPkg::*;

	romWord_t mem [romDepth];

	// Sixteen words per neuron row, bias in the last word.
	initial
	begin
		$readmemh("weights.mem", mem);
	end

	always_ff @(posedge clk)
	begin
		if (rdEn)
			rdData <= mem[rdAddr];    // One cycle read latency.
	end

endmodule

/* weights.mem */
// One signed 16-bit word per line, sixteen words per neuron row.
// Words 0 to 14 of a row are weights sign-extended from 8 bits, word 15 is the bias.
// Neuron 0
0001
0002
0003
0004
0005
0006
0007
0008
0009
000a
000b
000c
000d
000e
000f
0140
// Neuron 1
fff0
ffe8
fffc
ffe0
fff8
fff4
ffd0
fffe
ffec
ffe4
fff6
ffc8
fffa
fff2
ffdc
ff00
// Neuron 2
0010
fff0
0020
ffe0
0030
ffd0
0040
ffc0
0050
ffb0
0060
ffa0
0070
ff90
007f
1fe0
// Neuron 3
007f
ff80
0040
ffc0
0011
ffef
0022
ffde
0033
ffcd
0044
ffbc
0055
ffab
0066
2100
